//--- list.f
+incdir+design
design/mips_pkg.sv
design/stage_if.sv
design/hazard_unit.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/mips_core.sv
dv/wb_checker.sv
dv/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_top -f list.f --Mdir obj_dir -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log \
    && ! grep -q "TB FAILED" sim.log \
    || { echo "simulation failed"; exit 1; }

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top import mips_pkg::*; ();

    localparam int prog_len       = 200;
    localparam int rom_words      = 256;
    localparam int ram_words      = 16;  // 64-byte window
    localparam int seed           = 95;
    localparam int timeout_cycles = prog_len * 2 + 40;

    logic        clk;
    logic        reset;
    logic        final_check;
    logic        rom_ce;
    logic [31:0] rom_addr;
    logic [31:0] rom_data;
    logic        ram_ce;
    logic        ram_we;
    logic [3:0]  ram_sel;
    logic [31:0] ram_addr;
    logic [31:0] ram_wdata;
    logic [31:0] ram_rdata;
    logic [31:0] dbg_pc;
    logic [3:0]  dbg_wen;
    logic [4:0]  dbg_wnum;
    logic [31:0] dbg_wdata;
    logic [31:0] rom [rom_words];
    logic [31:0] ram [ram_words];
    logic [31:0] ram_init [ram_words];
    int          errors;
    int          writes;
    int          stores;

    function automatic logic [31:0] encode_r(funct_e fn, logic [4:0] rs, logic [4:0] rt,
                                             logic [4:0] rd);
        return {op_special, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encode_i(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                             logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    ////////////////////////////////////////////////////////////
    // random program and initial RAM image
    task automatic build_program();
        int unsigned pick;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        for (int i = 0; i < rom_words; i++)
            rom[i] = '0;
        for (int i = 0; i < ram_words; i++)
            ram_init[i] = 32'h9e37_79b9 * 32'(i + 1);
        for (int i = 0; i < 7; i++)
            rom[i] = encode_i(op_addiu, 5'd0, 5'(i + 1), 16'($urandom));  // seed r1..r7
        for (int i = 7; i < prog_len; i++) begin
            rs   = 5'($urandom_range(7, 1));
            rt   = 5'($urandom_range(7, 1));
            rd   = 5'($urandom_range(7, 0));  // r0 as a destination now and then
            imm  = 16'($urandom);
            pick = $urandom_range(14, 0);
            case (pick)
                0:       rom[i] = encode_r(fn_addu, rs, rt, rd);
                1:       rom[i] = encode_r(fn_subu, rs, rt, rd);
                2:       rom[i] = encode_r(fn_and, rs, rt, rd);
                3:       rom[i] = encode_r(fn_or, rs, rt, rd);
                4:       rom[i] = encode_r(fn_xor, rs, rt, rd);
                5:       rom[i] = encode_r(fn_slt, rs, rt, rd);
                6:       rom[i] = encode_r(fn_sltu, rs, rt, rd);
                7:       rom[i] = encode_i(op_addiu, rs, rt, imm);
                8:       rom[i] = encode_i(op_andi, rs, rt, imm);
                9:       rom[i] = encode_i(op_ori, rs, rt, imm);
                10:      rom[i] = encode_i(op_lui, 5'd0, rt, imm);
                11:      rom[i] = encode_i(op_lb, 5'd0, rt, 16'($urandom_range(63, 0)));
                12:      rom[i] = encode_i(op_lw, 5'd0, rt, 16'($urandom_range(15, 0) * 4));
                13:      rom[i] = encode_i(op_sb, 5'd0, rt, 16'($urandom_range(63, 0)));
                default: rom[i] = encode_i(op_sw, 5'd0, rt, 16'($urandom_range(15, 0) * 4));
            endcase
        end
    endtask

    always #2 clk = ~clk;

    assign rom_data  = rom[rom_addr[9:2]];
    assign ram_rdata = ram[ram_addr[5:2]];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ram_words; i++)
                ram[i] <= ram_init[i];
        end else if (ram_ce && ram_we) begin
            for (int i = 0; i < 4; i++)
                if (ram_sel[i])
                    ram[ram_addr[5:2]][8 * i +: 8] <= ram_wdata[8 * i +: 8];
        end
    end

    mips_core uut (
        .clk_i(clk), .reset_i(reset), .rom_data_i(rom_data), .ram_data_i(ram_rdata),
        .rom_ce_o(rom_ce), .rom_addr_o(rom_addr), .ram_ce_o(ram_ce), .ram_we_o(ram_we),
        .ram_sel_o(ram_sel), .ram_addr_o(ram_addr), .ram_wdata_o(ram_wdata),
        .debug_wb_pc_o(dbg_pc), .debug_wb_rf_wen_o(dbg_wen),
        .debug_wb_rf_wnum_o(dbg_wnum), .debug_wb_rf_wdata_o(dbg_wdata)
    );

    wb_checker #(.rom_words(rom_words), .ram_words(ram_words)) u_wb_check (
        .clk_i(clk), .reset_i(reset), .final_i(final_check),
        .rom_i(rom), .ram_init_i(ram_init),
        .rom_ce_i(rom_ce), .rom_addr_i(rom_addr), .ram_ce_i(ram_ce), .ram_we_i(ram_we),
        .ram_sel_i(ram_sel), .ram_addr_i(ram_addr), .ram_wdata_i(ram_wdata),
        .wb_pc_i(dbg_pc), .wb_wen_i(dbg_wen), .wb_wnum_i(dbg_wnum), .wb_wdata_i(dbg_wdata),
        .errors_o(errors), .writes_o(writes), .stores_o(stores)
    );

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        final_check = 1'b0;
        void'($urandom(seed));
        build_program();
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (rom_addr != 32'(prog_len * 4));
        // the last instruction is in decode and writes back within five cycles
        repeat (6) @(posedge clk);
        #1 final_check = 1'b1;
        @(posedge clk);
        #1;
        $display("checked %0d register writes and %0d stores, %0d errors",
                 writes, stores, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_cycles * 4);
        $display("timeout: the program did not drain within %0d cycles", timeout_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- dv/wb_checker.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module wb_checker import mips_pkg::*; #(
    parameter int rom_words = 256,
    parameter int ram_words = 16
) (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        final_i,
    input  logic [31:0] rom_i [rom_words],
    input  logic [31:0] ram_init_i [ram_words],
    input  logic        rom_ce_i,
    input  logic [31:0] rom_addr_i,
    input  logic        ram_ce_i,
    input  logic        ram_we_i,
    input  logic [3:0]  ram_sel_i,
    input  logic [31:0] ram_addr_i,
    input  logic [31:0] ram_wdata_i,
    input  logic [31:0] wb_pc_i,
    input  logic [3:0]  wb_wen_i,
    input  logic [4:0]  wb_wnum_i,
    input  logic [31:0] wb_wdata_i,
    output int          errors_o,
    output int          writes_o,
    output int          stores_o
);

    typedef enum {ev_none, ev_write, ev_store} event_e;

    logic [31:0] regs [`MIPS_REG_N];
    logic [31:0] mem [ram_words];
    int          idx;
    logic        drained;
    logic        running;
    int          errors = 0;
    int          writes = 0;
    int          stores = 0;
    event_e      exp_kind;
    logic [31:0] exp_pc;
    logic [31:0] exp_val;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    logic [4:0]  exp_wd;
    logic [3:0]  exp_sel;

    assign errors_o = errors;
    assign writes_o = writes;
    assign stores_o = stores;

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // instruction set model that runs until the next visible event
    task automatic advance_model();
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] addr;
        logic [7:0]  lb_val;
        exp_kind = ev_none;
        while (exp_kind == ev_none && idx < rom_words) begin
            inst     = rom_i[idx];
            a        = regs[inst[25:21]];
            b        = regs[inst[20:16]];
            sext     = {{16{inst[15]}}, inst[15:0]};
            zext     = {16'b0, inst[15:0]};
            addr     = a + sext;
            exp_pc   = 32'(idx * 4);
            exp_wd   = inst[20:16];
            exp_kind = ev_write;
            case (inst[31:26])
                op_special: begin
                    exp_wd = inst[15:11];
                    case (inst[5:0])
                        fn_addu: exp_val = a + b;
                        fn_subu: exp_val = a - b;
                        fn_and:  exp_val = a & b;
                        fn_or:   exp_val = a | b;
                        fn_xor:  exp_val = a ^ b;
                        fn_slt:  exp_val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fn_sltu: exp_val = (a < b) ? 32'd1 : 32'd0;
                        default: exp_kind = ev_none;
                    endcase
                end
                op_addiu: exp_val = a + sext;
                op_andi:  exp_val = a & zext;
                op_ori:   exp_val = a | zext;
                op_lui:   exp_val = {inst[15:0], 16'b0};
                op_lb: begin
                    lb_val  = mem[addr[5:2]][8 * addr[1:0] +: 8];
                    exp_val = {{24{lb_val[7]}}, lb_val};
                end
                op_lw:    exp_val = mem[addr[5:2]];
                op_sb, op_sw: begin
                    exp_kind  = ev_store;
                    exp_addr  = addr;
                    exp_sel   = (inst[31:26] == op_sb) ? (4'b0001 << addr[1:0]) : 4'b1111;
                    exp_wdata = (inst[31:26] == op_sb) ? {4{b[7:0]}} : b;
                end
                default:  exp_kind = ev_none;  // unknown opcode
            endcase
            if (exp_kind == ev_write && exp_wd == 5'd0)
                exp_kind = ev_none;  // r0 never shows on the debug port
            if (exp_kind == ev_write)
                regs[exp_wd] = exp_val;
            if (exp_kind == ev_store) begin
                for (int i = 0; i < 4; i++)
                    if (exp_sel[i])
                        mem[addr[5:2]][8 * i +: 8] = exp_wdata[8 * i +: 8];
            end
            idx++;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `MIPS_REG_N; i++)
                regs[i] = '0;
            for (int i = 0; i < ram_words; i++)
                mem[i] = ram_init_i[i];
            idx     = 0;
            drained = 1'b0;
            running = 1'b0;
            compare_field("rom_addr_o", `MIPS_RESET_PC, rom_addr_i);
            compare_field("rom_ce_o", 32'd0, 32'(rom_ce_i));
            compare_field("ram_we_o", 32'd0, 32'(ram_we_i));
            compare_field("debug_wb_rf_wen_o", 32'd0, 32'(wb_wen_i));
        end else begin
            // rom_ce_o rises one cycle after reset is released
            if (running)
                compare_field("rom_ce_o", 32'd1, 32'(rom_ce_i));
            running = 1'b1;
            // writeback is older than the store in memory
            if (wb_wen_i != 4'b0) begin
                writes++;
                advance_model();
                if (exp_kind != ev_write) begin
                    errors++;
                    $display("at %0t ns the DUT wrote r%0d but the model expected %s",
                             $time, wb_wnum_i, exp_kind.name());
                end else begin
                    compare_field("debug_wb_pc_o", exp_pc, wb_pc_i);
                    compare_field("debug_wb_rf_wen_o", 32'hf, 32'(wb_wen_i));
                    compare_field("debug_wb_rf_wnum_o", 32'(exp_wd), 32'(wb_wnum_i));
                    compare_field("debug_wb_rf_wdata_o", exp_val, wb_wdata_i);
                end
            end
            if (ram_we_i) begin
                stores++;
                advance_model();
                if (exp_kind != ev_store) begin
                    errors++;
                    $display("at %0t ns the DUT stored to %h but the model expected %s",
                             $time, ram_addr_i, exp_kind.name());
                end else begin
                    compare_field("ram_ce_o", 32'd1, 32'(ram_ce_i));
                    compare_field("ram_addr_o", exp_addr, ram_addr_i);
                    compare_field("ram_sel_o", 32'(exp_sel), 32'(ram_sel_i));
                    compare_field("ram_wdata_o", exp_wdata, ram_wdata_i);
                end
            end
            if (final_i && !drained) begin
                drained = 1'b1;
                advance_model();
                if (exp_kind != ev_none) begin
                    errors++;
                    $display("the run ended with a missing %s from pc %h",
                             exp_kind.name(), exp_pc);
                end
            end
        end
    end

endmodule

//--- design/mips_core.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_core import mips_pkg::*; (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic [`MIPS_DATA_W-1:0]  rom_data_i,
    input  logic [`MIPS_DATA_W-1:0]  ram_data_i,
    output logic                     rom_ce_o,
    output logic [`MIPS_DATA_W-1:0]  rom_addr_o,
    output logic                     ram_ce_o,
    output logic                     ram_we_o,
    output logic [3:0]               ram_sel_o,
    output logic [`MIPS_DATA_W-1:0]  ram_addr_o,
    output logic [`MIPS_DATA_W-1:0]  ram_wdata_o,
    output logic [`MIPS_DATA_W-1:0]  debug_wb_pc_o,
    output logic [3:0]               debug_wb_rf_wen_o,
    output logic [`MIPS_REG_AW-1:0]  debug_wb_rf_wnum_o,
    output logic [`MIPS_DATA_W-1:0]  debug_wb_rf_wdata_o
);

    logic [`MIPS_DATA_W-1:0] id_pc;
    logic [`MIPS_DATA_W-1:0] id_inst;
    logic [`MIPS_REG_AW-1:0] rs;
    logic [`MIPS_REG_AW-1:0] rt;
    logic                    rs_used;
    logic                    rt_used;
    fwd_sel_e                fwd_a;
    fwd_sel_e                fwd_b;
    logic                    stall;
    logic [`MIPS_DATA_W-1:0] ex_result;
    logic [`MIPS_DATA_W-1:0] mem_result;
    logic                    wb_we;
    logic [`MIPS_REG_AW-1:0] wb_wd;
    logic [`MIPS_DATA_W-1:0] wb_wdata;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    hazard_unit u_hazard (
        .rs_i(rs), .rt_i(rt), .rs_used_i(rs_used), .rt_used_i(rt_used),
        .ex_mem_i(ex_mem.consumer),
        .ex_wd_i(id_ex.wd), .ex_wreg_i(id_ex.wreg), .ex_load_i(id_ex.load),
        .wb_wd_i(wb_wd), .wb_wreg_i(wb_we),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .stall_o(stall)
    );

    fetch_stage u_fetch (
        .clk_i(clk_i), .reset_i(reset_i), .stall_i(stall), .inst_i(rom_data_i),
        .pc_o(rom_addr_o), .ce_o(rom_ce_o), .id_pc_o(id_pc), .id_inst_o(id_inst)
    );

    decode_stage u_decode (
        .clk_i(clk_i), .reset_i(reset_i), .pc_i(id_pc), .inst_i(id_inst), .stall_i(stall),
        .fwd_a_i(fwd_a), .fwd_b_i(fwd_b),
        .ex_result_i(ex_result), .mem_result_i(mem_result),
        .wb_we_i(wb_we), .wb_wd_i(wb_wd), .wb_wdata_i(wb_wdata),
        .rs_o(rs), .rt_o(rt), .rs_used_o(rs_used), .rt_used_o(rt_used),
        .id_ex_o(id_ex.producer)
    );

    execute_stage u_execute (
        .clk_i(clk_i), .reset_i(reset_i), .id_ex_i(id_ex.consumer),
        .result_o(ex_result), .ex_mem_o(ex_mem.producer)
    );

    memory_stage u_memory (
        .clk_i(clk_i), .reset_i(reset_i), .ex_mem_i(ex_mem.consumer), .ram_data_i(ram_data_i),
        .ram_ce_o(ram_ce_o), .ram_we_o(ram_we_o), .ram_sel_o(ram_sel_o),
        .ram_addr_o(ram_addr_o), .ram_wdata_o(ram_wdata_o), .result_o(mem_result),
        .wb_we_o(wb_we), .wb_wd_o(wb_wd), .wb_wdata_o(wb_wdata),
        .debug_wb_pc_o(debug_wb_pc_o), .debug_wb_rf_wen_o(debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o(debug_wb_rf_wnum_o), .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

endmodule

//--- design/memory_stage.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module memory_stage (
    input  logic                     clk_i,
    input  logic                     reset_i,
    ex_mem_if.consumer               ex_mem_i,
    input  logic [`MIPS_DATA_W-1:0]  ram_data_i,
    output logic                     ram_ce_o,
    output logic                     ram_we_o,
    output logic [3:0]               ram_sel_o,
    output logic [`MIPS_DATA_W-1:0]  ram_addr_o,
    output logic [`MIPS_DATA_W-1:0]  ram_wdata_o,
    output logic [`MIPS_DATA_W-1:0]  result_o,
    output logic                     wb_we_o,
    output logic [`MIPS_REG_AW-1:0]  wb_wd_o,
    output logic [`MIPS_DATA_W-1:0]  wb_wdata_o,
    output logic [`MIPS_DATA_W-1:0]  debug_wb_pc_o,
    output logic [3:0]               debug_wb_rf_wen_o,
    output logic [`MIPS_REG_AW-1:0]  debug_wb_rf_wnum_o,
    output logic [`MIPS_DATA_W-1:0]  debug_wb_rf_wdata_o
);

    logic [1:0]              lane;
    logic [7:0]              load_byte;
    logic [`MIPS_DATA_W-1:0] load_data;
    logic [`MIPS_DATA_W-1:0] wb_pc;

    assign lane = ex_mem_i.result[1:0];

    ////////////////////////////////////////////////////////////
    // data port
    assign ram_ce_o    = ex_mem_i.load | ex_mem_i.store;
    assign ram_we_o    = ex_mem_i.store;
    assign ram_addr_o  = ex_mem_i.result;
    assign ram_sel_o   = ex_mem_i.is_byte ? (4'b0001 << lane) : 4'b1111;
    assign ram_wdata_o = ex_mem_i.is_byte ? {4{ex_mem_i.sdata[7:0]}} : ex_mem_i.sdata;

    // lb picks the addressed lane and sign-extends
    assign load_byte = ram_data_i[8*lane +: 8];
    assign load_data = ex_mem_i.is_byte ? {{24{load_byte[7]}}, load_byte} : ram_data_i;
    assign result_o  = ex_mem_i.load ? load_data : ex_mem_i.result;

    ////////////////////////////////////////////////////////////
    // mem/wb register
    always_ff @(posedge clk_i) begin
        if (reset_i)
            wb_we_o <= 1'b0;
        else
            wb_we_o <= ex_mem_i.wreg;
    end

    always_ff @(posedge clk_i) begin
        wb_wd_o    <= ex_mem_i.wd;
        wb_wdata_o <= result_o;
        wb_pc      <= ex_mem_i.pc;
    end

    assign debug_wb_pc_o       = wb_pc;
    assign debug_wb_rf_wen_o   = {4{wb_we_o}};
    assign debug_wb_rf_wnum_o  = wb_wd_o;
    assign debug_wb_rf_wdata_o = wb_wdata_o;

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module execute_stage import mips_pkg::*; (
    input  logic                     clk_i,
    input  logic                     reset_i,
    id_ex_if.consumer                id_ex_i,
    output logic [`MIPS_DATA_W-1:0]  result_o,  // also the bypass to decode
    ex_mem_if.producer               ex_mem_o
);

    logic [`MIPS_DATA_W-1:0] a;
    logic [`MIPS_DATA_W-1:0] b;

    assign a = id_ex_i.a;
    assign b = id_ex_i.b;

    // loads and stores come through as alu_add, giving the address
    always_comb begin
        case (id_ex_i.alu_op)
            alu_add:  result_o = a + b;
            alu_sub:  result_o = a - b;
            alu_and:  result_o = a & b;
            alu_or:   result_o = a | b;
            alu_xor:  result_o = a ^ b;
            alu_slt:  result_o = {{(`MIPS_DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result_o = {{(`MIPS_DATA_W-1){1'b0}}, a < b};
            alu_lui:  result_o = {b[15:0], 16'b0};
            default:  result_o = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // ex/mem register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ex_mem_o.wreg  <= 1'b0;
            ex_mem_o.load  <= 1'b0;
            ex_mem_o.store <= 1'b0;
        end else begin
            ex_mem_o.wreg  <= id_ex_i.wreg;
            ex_mem_o.load  <= id_ex_i.load;
            ex_mem_o.store <= id_ex_i.store;
        end
    end

    always_ff @(posedge clk_i) begin
        ex_mem_o.result  <= result_o;
        ex_mem_o.sdata   <= id_ex_i.sdata;
        ex_mem_o.wd      <= id_ex_i.wd;
        ex_mem_o.is_byte <= id_ex_i.is_byte;
        ex_mem_o.pc      <= id_ex_i.pc;
    end

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module decode_stage import mips_pkg::*; (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic [`MIPS_DATA_W-1:0]  pc_i,
    input  logic [`MIPS_DATA_W-1:0]  inst_i,
    input  logic                     stall_i,
    input  fwd_sel_e                 fwd_a_i,
    input  fwd_sel_e                 fwd_b_i,
    input  logic [`MIPS_DATA_W-1:0]  ex_result_i,
    input  logic [`MIPS_DATA_W-1:0]  mem_result_i,
    input  logic                     wb_we_i,
    input  logic [`MIPS_REG_AW-1:0]  wb_wd_i,
    input  logic [`MIPS_DATA_W-1:0]  wb_wdata_i,
    output logic [`MIPS_REG_AW-1:0]  rs_o,
    output logic [`MIPS_REG_AW-1:0]  rt_o,
    output logic                     rs_used_o,
    output logic                     rt_used_o,
    id_ex_if.producer                id_ex_o
);

    opcode_e                   opcode;
    funct_e                    funct;
    logic [`MIPS_REG_AW-1:0]   rd;
    logic [15:0]               imm;
    logic [`MIPS_DATA_W-1:0]   imm_ext;
    logic [`MIPS_DATA_W-1:0]   regs [0:`MIPS_REG_N-1];
    logic [`MIPS_DATA_W-1:0]   rf_a;
    logic [`MIPS_DATA_W-1:0]   rf_b;
    logic [`MIPS_DATA_W-1:0]   op_a;
    logic [`MIPS_DATA_W-1:0]   op_b;
    alu_op_e                   alu_op;
    logic                      wreg;
    logic                      wd_rt;
    logic                      use_imm;
    logic                      imm_zext;
    logic                      load;
    logic                      store;
    logic                      is_byte;
    logic [`MIPS_REG_AW-1:0]   wd;

    assign opcode = opcode_e'(inst_i[31:26]);
    assign funct  = funct_e'(inst_i[5:0]);
    assign rs_o   = inst_i[25:21];
    assign rt_o   = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign imm    = inst_i[15:0];

    ////////////////////////////////////////////////////////////
    // decoder
    always_comb begin
        alu_op    = alu_add;
        wreg      = 1'b0;
        wd_rt     = 1'b1;
        use_imm   = 1'b1;
        imm_zext  = 1'b0;
        load      = 1'b0;
        store     = 1'b0;
        is_byte   = 1'b0;
        rs_used_o = 1'b0;
        rt_used_o = 1'b0;
        case (opcode)
            op_special: begin
                wreg      = 1'b1;
                wd_rt     = 1'b0;
                use_imm   = 1'b0;
                rs_used_o = 1'b1;
                rt_used_o = 1'b1;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    default: begin  // unknown funct, nop
                        wreg      = 1'b0;
                        rs_used_o = 1'b0;
                        rt_used_o = 1'b0;
                    end
                endcase
            end
            op_addiu: begin
                wreg      = 1'b1;
                rs_used_o = 1'b1;
            end
            op_andi, op_ori: begin
                wreg      = 1'b1;
                rs_used_o = 1'b1;
                imm_zext  = 1'b1;
                alu_op    = (opcode == op_andi) ? alu_and : alu_or;
            end
            op_lui: begin
                wreg     = 1'b1;
                imm_zext = 1'b1;
                alu_op   = alu_lui;
            end
            op_lb, op_lw: begin
                wreg      = 1'b1;
                load      = 1'b1;
                is_byte   = (opcode == op_lb);
                rs_used_o = 1'b1;
            end
            op_sb, op_sw: begin
                store     = 1'b1;
                is_byte   = (opcode == op_sb);
                rs_used_o = 1'b1;
                rt_used_o = 1'b1;
            end
            default: ;  // nop
        endcase
    end

    assign wd      = wd_rt ? rt_o : rd;
    assign imm_ext = imm_zext ? {16'b0, imm} : {{16{imm[15]}}, imm};

    ////////////////////////////////////////////////////////////
    // register file and bypass
    always_ff @(posedge clk_i) begin
        if (wb_we_i && wb_wd_i != '0)
            regs[wb_wd_i] <= wb_wdata_i;
    end

    assign rf_a = (rs_o == '0) ? '0 : regs[rs_o];
    assign rf_b = (rt_o == '0) ? '0 : regs[rt_o];

    function automatic logic [`MIPS_DATA_W-1:0] bypass(input fwd_sel_e sel,
                                                     input logic [`MIPS_DATA_W-1:0] rf_val);
        case (sel)
            fwd_ex:  return ex_result_i;
            fwd_mem: return mem_result_i;
            fwd_wb:  return wb_wdata_i;
            default: return rf_val;
        endcase
    endfunction

    assign op_a = bypass(fwd_a_i, rf_a);
    assign op_b = bypass(fwd_b_i, rf_b);

    ////////////////////////////////////////////////////////////
    // id/ex register
    always_ff @(posedge clk_i) begin
        if (reset_i || stall_i) begin  // bubble
            id_ex_o.wreg  <= 1'b0;
            id_ex_o.load  <= 1'b0;
            id_ex_o.store <= 1'b0;
        end else begin
            id_ex_o.wreg  <= wreg && (wd != '0);  // r0 writes dropped here
            id_ex_o.load  <= load;
            id_ex_o.store <= store;
        end
    end

    always_ff @(posedge clk_i) begin
        id_ex_o.alu_op  <= alu_op;
        id_ex_o.a       <= op_a;
        id_ex_o.b       <= use_imm ? imm_ext : op_b;
        id_ex_o.sdata   <= op_b;
        id_ex_o.wd      <= wd;
        id_ex_o.is_byte <= is_byte;
        id_ex_o.pc      <= pc_i;
    end

endmodule

//--- design/fetch_stage.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module fetch_stage (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     stall_i,
    input  logic [`MIPS_DATA_W-1:0]  inst_i,
    output logic [`MIPS_DATA_W-1:0]  pc_o,
    output logic                     ce_o,
    output logic [`MIPS_DATA_W-1:0]  id_pc_o,
    output logic [`MIPS_DATA_W-1:0]  id_inst_o
);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_o      <= `MIPS_RESET_PC;
            ce_o      <= 1'b0;
            id_pc_o   <= `MIPS_RESET_PC;
            id_inst_o <= '0;  // sll r0 = nop
        end else begin
            ce_o <= 1'b1;
            if (!stall_i) begin
                if (ce_o)
                    pc_o <= pc_o + 32'd4;
                id_pc_o   <= pc_o;
                id_inst_o <= ce_o ? inst_i : '0;
            end
        end
    end

endmodule

//--- design/hazard_unit.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module hazard_unit import mips_pkg::*; (
    input  logic [`MIPS_REG_AW-1:0]  rs_i,
    input  logic [`MIPS_REG_AW-1:0]  rt_i,
    input  logic                     rs_used_i,
    input  logic                     rt_used_i,
    ex_mem_if.consumer               ex_mem_i,
    input  logic [`MIPS_REG_AW-1:0]  ex_wd_i,
    input  logic                     ex_wreg_i,
    input  logic                     ex_load_i,
    input  logic [`MIPS_REG_AW-1:0]  wb_wd_i,
    input  logic                     wb_wreg_i,
    output fwd_sel_e                 fwd_a_o,
    output fwd_sel_e                 fwd_b_o,
    output logic                     stall_o
);

    logic [`MIPS_REG_AW-1:0] mem_wd;
    logic                    mem_wreg;

    assign mem_wd   = ex_mem_i.wd;
    assign mem_wreg = ex_mem_i.wreg;

    // youngest writer wins, r0 always from the register file
    function automatic fwd_sel_e pick_src(input logic [`MIPS_REG_AW-1:0] src);
        if (src == '0)
            return fwd_rf;
        if (ex_wreg_i && ex_wd_i == src)
            return fwd_ex;
        if (mem_wreg && mem_wd == src)
            return fwd_mem;
        if (wb_wreg_i && wb_wd_i == src)
            return fwd_wb;
        return fwd_rf;
    endfunction

    assign fwd_a_o = pick_src(rs_i);
    assign fwd_b_o = pick_src(rt_i);

    // load data only exists in memory, so hold decode one cycle
    assign stall_o = ex_load_i && ex_wreg_i &&
                     ((rs_used_i && rs_i == ex_wd_i) || (rt_used_i && rt_i == ex_wd_i));

endmodule

//--- design/stage_if.sv
`timescale 1ns/1ps
`include "mips_config.svh"

// decode -> execute
interface id_ex_if import mips_pkg::*; ();
    alu_op_e                   alu_op;
    logic [`MIPS_DATA_W-1:0]   a;
    logic [`MIPS_DATA_W-1:0]   b;
    logic [`MIPS_DATA_W-1:0]   sdata;   // rt value for stores
    logic [`MIPS_REG_AW-1:0]   wd;
    logic                      wreg;
    logic                      load;
    logic                      store;
    logic                      is_byte;
    logic [`MIPS_DATA_W-1:0]   pc;

    modport producer (output alu_op, a, b, sdata, wd, wreg, load, store, is_byte, pc);
    modport consumer (input  alu_op, a, b, sdata, wd, wreg, load, store, is_byte, pc);
endinterface

// execute -> memory
interface ex_mem_if ();
    logic [`MIPS_DATA_W-1:0]   result;  // alu result or data address
    logic [`MIPS_DATA_W-1:0]   sdata;
    logic [`MIPS_REG_AW-1:0]   wd;
    logic                      wreg;
    logic                      load;
    logic                      store;
    logic                      is_byte;
    logic [`MIPS_DATA_W-1:0]   pc;

    modport producer (output result, sdata, wd, wreg, load, store, is_byte, pc);
    modport consumer (input  result, sdata, wd, wreg, load, store, is_byte, pc);
endinterface

//--- design/mips_pkg.sv
package mips_pkg;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_addiu   = 6'h09,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lb      = 6'h20,
        op_lw      = 6'h23,
        op_sb      = 6'h28,
        op_sw      = 6'h2b
    } opcode_e;

    // function code of op_special, inst[5:0]
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sltu, alu_lui
    } alu_op_e;

    // operand source picked by the hazard unit
    typedef enum logic [1:0] {fwd_rf, fwd_ex, fwd_mem, fwd_wb} fwd_sel_e;

endpackage

//--- design/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// datapath and address width
`define MIPS_DATA_W 32

// general purpose register file
`define MIPS_REG_N 32
`define MIPS_REG_AW 5

// first fetch address
`define MIPS_RESET_PC 32'h0000_0000

`endif
